//--- logic/dcache_pkg.sv
package dcache_pkg;

    localparam int WAY_NUM    = 2;
    localparam int WORD_BYTES = 4;

    // defaults handed down by the top level
    localparam int line_words_default = 4;
    localparam int set_num_default    = 16;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } cpu_resp_t;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,  // victim write request pending
        WRITEBACK,
        MISS_CLEAN,  // line read request pending
        REFILL,
        REFILL_DONE  // arrays re-read at the stalled index
    } miss_state_e;

    // one bit per way, at most one set
    typedef logic [WAY_NUM-1:0] way_sel_t;

endpackage

//--- logic/tag_dirty_array.sv
module tag_dirty_array import dcache_pkg::*; #(
    parameter int  LINE_WORDS = line_words_default,
    parameter int  SET_NUM    = set_num_default,
    localparam int INDEX_W    = $clog2(SET_NUM),
    localparam int OFFSET_W   = $clog2(LINE_WORDS * WORD_BYTES),
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [INDEX_W-1:0] index,
    input  logic [TAG_W-1:0]   cur_tag,
    output way_sel_t           hit,
    output logic               victim_dirty,
    output logic [TAG_W-1:0]   victim_tag,
    input  logic               victim,
    input  logic               fill_we,
    input  logic               store_hit_we
);
    logic [TAG_W-1:0]                tags [WAY_NUM][SET_NUM];
    logic [WAY_NUM-1:0][SET_NUM-1:0] valid;
    logic [WAY_NUM-1:0][SET_NUM-1:0] dirty;

    logic [TAG_W-1:0]   tag_q [WAY_NUM];
    logic [WAY_NUM-1:0] valid_q;
    logic [WAY_NUM-1:0] dirty_q;
    logic [INDEX_W-1:0] index_q;  // set of the request in lookup

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tags[victim][index_q] <= cur_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_we) begin
            valid[victim][index_q] <= 1'b1;
            dirty[victim][index_q] <= 1'b0;  // fresh line is clean
        end else if (store_hit_we) begin
            dirty[hit[1]][index_q] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        index_q <= index;
        for (int w = 0; w < WAY_NUM; w++) begin
            tag_q[w] <= tags[w][index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < WAY_NUM; w++) begin
                valid_q[w] <= valid[w][index];
                dirty_q[w] <= dirty[w][index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cur_tag);
        end
    end

    assign victim_dirty = dirty_q[victim];
    assign victim_tag   = tag_q[victim];

    // refill belongs to the miss FSM, store hit to the lookup stage
    assert property (@(posedge clk) disable iff (reset) !(fill_we && store_hit_we));

endmodule

//--- logic/line_data_array.sv
module line_data_array import dcache_pkg::*; #(
    parameter int  LINE_WORDS = line_words_default,
    parameter int  SET_NUM    = set_num_default,
    localparam int INDEX_W    = $clog2(SET_NUM),
    localparam int WORD_W     = $clog2(LINE_WORDS)
) (
    input  logic                                  clk,
    input  logic [INDEX_W-1:0]                    read_index,
    input  logic                                  read_en,
    input  logic [INDEX_W-1:0]                    write_index,
    input  logic                                  fill_we,
    input  logic                                  fill_way,
    input  logic [LINE_WORDS*32-1:0]              fill_line,
    input  logic                                  store_we,
    input  way_sel_t                              store_way,
    input  logic [WORD_W-1:0]                     store_offset,
    input  logic [31:0]                           store_word,
    output logic [WAY_NUM-1:0][LINE_WORDS*32-1:0] way_words
);
    logic [31:0]                        mem [WAY_NUM][LINE_WORDS][SET_NUM];
    logic [WAY_NUM-1:0][LINE_WORDS-1:0] word_we;
    logic [LINE_WORDS-1:0][31:0]        word_wdata;

    always_comb begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            word_wdata[i] = fill_we ? fill_line[i*32 +: 32] : store_word;
        end
        for (int w = 0; w < WAY_NUM; w++) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                word_we[w][i] = (fill_we && (fill_way == 1'(w)))
                    || (store_we && store_way[w] && (store_offset == WORD_W'(i)));
            end
        end
    end

    // read before write on the same set
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAY_NUM; w++) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                if (word_we[w][i]) begin
                    mem[w][i][write_index] <= word_wdata[i];
                end
                if (read_en) begin
                    way_words[w][i*32 +: 32] <= mem[w][i][read_index];
                end
            end
        end
    end

endmodule

//--- logic/lru_bank.sv
module lru_bank import dcache_pkg::*; #(
    parameter int  SET_NUM = set_num_default,
    localparam int INDEX_W = $clog2(SET_NUM)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [INDEX_W-1:0] index,
    input  logic               update,
    input  way_sel_t           hit,
    output logic               victim
);
    // one bit per set, names the way not used last
    logic [SET_NUM-1:0] lru;

    // a refill is always followed by a hit on the filled way,
    // so that hit covers the refill update too
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (update) begin
            lru[index] <= hit[0];  // way 0 used, way 1 goes next
        end
    end

    assign victim = lru[index];

endmodule

//--- logic/lookup_stage.sv
module lookup_stage import dcache_pkg::*; #(
    parameter int  LINE_WORDS = line_words_default,
    parameter int  SET_NUM    = set_num_default,
    localparam int INDEX_W    = $clog2(SET_NUM),
    localparam int OFFSET_W   = $clog2(LINE_WORDS * WORD_BYTES)
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  cpu_req_t                              req,
    input  logic                                  stall,
    output logic [INDEX_W-1:0]                    read_index,
    input  way_sel_t                              hit,
    input  logic [WAY_NUM-1:0][LINE_WORDS*32-1:0] way_words,
    output cpu_resp_t                             resp,
    output cpu_req_t                              cur_req,
    output logic                                  store_we,
    output logic [31:0]                           store_word
);
    localparam int WORD_W = OFFSET_W - 2;

    logic              fwd_valid;
    logic [29:0]       fwd_addr;
    logic [31:0]       fwd_word;
    logic              fwd_hit;
    logic [WORD_W-1:0] word_sel;
    logic [31:0]       array_word;
    logic [31:0]       load_word;

    // held request keeps its set on the array address while stalled
    assign read_index = stall ? cur_req.addr[OFFSET_W +: INDEX_W]
                              : req.addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_req <= '0;
        end else if (!stall) begin
            cur_req <= req;
        end
    end

    assign word_sel   = cur_req.addr[OFFSET_W-1:2];
    assign array_word = way_words[hit[1]][word_sel*32 +: 32];

    // the array read for this request saw the word before the last store landed
    assign fwd_hit   = fwd_valid && (fwd_addr == cur_req.addr[31:2]);
    assign load_word = fwd_hit ? fwd_word : array_word;

    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            store_word[b*8 +: 8] = cur_req.wstrb[b] ? cur_req.wdata[b*8 +: 8]
                                                    : load_word[b*8 +: 8];
        end
    end

    always_comb begin
        resp.valid = cur_req.valid && (|hit);
        resp.rdata = load_word;
    end

    assign store_we = resp.valid && (cur_req.op == OP_STORE);

    always_ff @(posedge clk) begin
        if (reset) begin
            fwd_valid <= 1'b0;
        end else if (stall) begin
            fwd_valid <= 1'b0;  // refill path re-reads the arrays
        end else begin
            fwd_valid <= store_we;
        end
    end

    always_ff @(posedge clk) begin
        if (store_we) begin
            fwd_addr <= cur_req.addr[31:2];
            fwd_word <= store_word;
        end
    end

    // a set never holds one tag in both ways
    assert property (@(posedge clk) disable iff (reset) cur_req.valid |-> $onehot0(hit));

endmodule

//--- logic/miss_ctrl.sv
module miss_ctrl import dcache_pkg::*; #(
    parameter int  LINE_WORDS = line_words_default,
    parameter int  SET_NUM    = set_num_default,
    localparam int INDEX_W    = $clog2(SET_NUM),
    localparam int OFFSET_W   = $clog2(LINE_WORDS * WORD_BYTES),
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  lookup_valid,
    input  way_sel_t                              hit,
    input  logic                                  victim,
    input  logic                                  victim_dirty,
    input  logic [TAG_W-1:0]                      victim_tag,
    input  cpu_req_t                              cur_req,
    input  logic [WAY_NUM-1:0][LINE_WORDS*32-1:0] line_words,
    output logic                                  busy,
    output logic                                  stall,
    output logic                                  read_en,
    output logic                                  fill_we,
    output logic                                  rd_req,
    output logic [31:0]                           rd_addr,
    input  logic                                  rd_rdy,
    input  logic                                  ret_valid,
    output logic                                  wr_req,
    output logic [31:0]                           wr_addr,
    output logic [LINE_WORDS*32-1:0]              wr_data,
    input  logic                                  wr_rdy,
    input  logic                                  wr_done
);
    miss_state_e state;
    miss_state_e state_next;
    logic        miss;

    assign miss = lookup_valid && !(|hit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (miss) begin
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (wr_rdy) begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (wr_done) begin
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_next = REFILL_DONE;
                end
            end
            REFILL_DONE: state_next = LOOKUP;
            default:     state_next = LOOKUP;
        endcase
    end

    // rises in the miss cycle itself
    assign busy  = (state == LOOKUP) ? miss : 1'b1;
    assign stall = busy;

    // data regs keep the victim line through writeback
    assign read_en = !busy || (state == REFILL_DONE);
    assign fill_we = (state == REFILL) && ret_valid;

    assign rd_req  = (state == MISS_CLEAN);
    assign rd_addr = {cur_req.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    assign wr_req  = (state == MISS_DIRTY);
    assign wr_addr = {victim_tag, cur_req.addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
    assign wr_data = line_words[victim];

    assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req));

    // refilled line must hit on the re-read
    assert property (@(posedge clk) disable iff (reset)
        (state == REFILL_DONE) |=> (|hit));

endmodule

//--- logic/dcache_top.sv
module dcache_top import dcache_pkg::*; #(
    parameter int LINE_WORDS = line_words_default,
    parameter int SET_NUM    = set_num_default
) (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_req_t                 req,
    output logic                     busy,
    output cpu_resp_t                resp,
    output logic                     rd_req,
    output logic [31:0]              rd_addr,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  logic [LINE_WORDS*32-1:0] ret_data,
    output logic                     wr_req,
    output logic [31:0]              wr_addr,
    output logic [LINE_WORDS*32-1:0] wr_data,
    input  logic                     wr_rdy,
    input  logic                     wr_done
);
    localparam int INDEX_W  = $clog2(SET_NUM);
    localparam int OFFSET_W = $clog2(LINE_WORDS * WORD_BYTES);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    cpu_req_t                              cur_req;
    logic [INDEX_W-1:0]                    read_index;
    way_sel_t                              hit;
    logic                                  victim;
    logic                                  victim_dirty;
    logic [TAG_W-1:0]                      victim_tag;
    logic [WAY_NUM-1:0][LINE_WORDS*32-1:0] way_words;
    logic                                  stall;
    logic                                  read_en;
    logic                                  fill_we;
    logic                                  store_we;
    logic [31:0]                           store_word;

    lookup_stage #(.LINE_WORDS(LINE_WORDS), .SET_NUM(SET_NUM)) lookup_i (
        .clk(clk), .reset(reset), .req(req), .stall(stall), .read_index(read_index),
        .hit(hit), .way_words(way_words), .resp(resp), .cur_req(cur_req),
        .store_we(store_we), .store_word(store_word)
    );

    tag_dirty_array #(.LINE_WORDS(LINE_WORDS), .SET_NUM(SET_NUM)) tags_i (
        .clk(clk), .reset(reset), .index(read_index), .cur_tag(cur_req.addr[31 -: TAG_W]),
        .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag), .victim(victim),
        .fill_we(fill_we), .store_hit_we(store_we)
    );

    line_data_array #(.LINE_WORDS(LINE_WORDS), .SET_NUM(SET_NUM)) data_i (
        .clk(clk), .read_index(read_index), .read_en(read_en),
        .write_index(cur_req.addr[OFFSET_W +: INDEX_W]),
        .fill_we(fill_we), .fill_way(victim), .fill_line(ret_data),
        .store_we(store_we), .store_way(hit), .store_offset(cur_req.addr[OFFSET_W-1:2]),
        .store_word(store_word), .way_words(way_words)
    );

    // bit moves on every completed access
    lru_bank #(.SET_NUM(SET_NUM)) lru_i (
        .clk(clk), .reset(reset), .index(cur_req.addr[OFFSET_W +: INDEX_W]),
        .update(resp.valid), .hit(hit), .victim(victim)
    );

    miss_ctrl #(.LINE_WORDS(LINE_WORDS), .SET_NUM(SET_NUM)) miss_i (
        .clk(clk), .reset(reset), .lookup_valid(cur_req.valid), .hit(hit), .victim(victim),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag), .cur_req(cur_req),
        .line_words(way_words), .busy(busy), .stall(stall), .read_en(read_en),
        .fill_we(fill_we), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_rdy(wr_rdy), .wr_done(wr_done)
    );

endmodule

//--- tb/mem_model.sv
module mem_model import dcache_pkg::*; #(
    parameter int          LINE_WORDS = line_words_default,
    parameter logic [31:0] SEED       = 32'h2260
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rd_req,
    input  logic [31:0]              rd_addr,
    output logic                     rd_rdy,
    output logic                     ret_valid,
    output logic [LINE_WORDS*32-1:0] ret_data,
    input  logic                     wr_req,
    input  logic [31:0]              wr_addr,
    input  logic [LINE_WORDS*32-1:0] wr_data,
    output logic                     wr_rdy,
    output logic                     wr_done
);
    logic [31:0]              mem [4096];  // 16 KB on word address bits 13:2
    integer                   seed = SEED;
    integer                   rnd;
    logic [1:0]               rd_wait;
    logic [1:0]               ret_wait;
    logic                     rd_busy;
    logic [31:0]              rd_line;
    logic [1:0]               wr_wait;
    logic [1:0]               done_wait;
    logic                     wr_busy;
    logic [31:0]              wr_line;
    logic [LINE_WORDS*32-1:0] wr_buf;

    function automatic logic [31:0] word_pattern(logic [31:0] addr);
        return {addr[15:0] ^ addr[31:16], ~addr[15:0]} ^ 32'h3c96_a5f0;
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wr_done   = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = word_pattern({18'b0, 12'(i), 2'b00});
        end
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        ret_valid <= 1'b0;
        wr_done   <= 1'b0;
        if (reset) begin
            rd_rdy  <= 1'b0;
            rd_busy <= 1'b0;
            wr_rdy  <= 1'b0;
            wr_busy <= 1'b0;
            rd_wait <= rnd[1:0];
            wr_wait <= rnd[3:2];
        end else begin
            if (rd_req && rd_rdy) begin
                rd_rdy   <= 1'b0;
                rd_busy  <= 1'b1;
                rd_line  <= rd_addr;
                ret_wait <= rnd[5:4];
            end else if (rd_req && !rd_busy) begin
                if (rd_wait == 0) rd_rdy <= 1'b1;
                else rd_wait <= rd_wait - 1'b1;
            end
            if (rd_busy) begin
                if (ret_wait == 0) begin
                    ret_valid <= 1'b1;
                    rd_busy   <= 1'b0;
                    rd_wait   <= rnd[7:6];
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        ret_data[i*32 +: 32] <= mem[rd_line[13:2] + 12'(i)];
                    end
                end else begin
                    ret_wait <= ret_wait - 1'b1;
                end
            end
            if (wr_req && wr_rdy) begin
                wr_rdy    <= 1'b0;
                wr_busy   <= 1'b1;
                wr_line   <= wr_addr;
                wr_buf    <= wr_data;
                done_wait <= rnd[9:8];
            end else if (wr_req && !wr_busy) begin
                if (wr_wait == 0) wr_rdy <= 1'b1;
                else wr_wait <= wr_wait - 1'b1;
            end
            if (wr_busy) begin
                if (done_wait == 0) begin
                    wr_done <= 1'b1;
                    wr_busy <= 1'b0;
                    wr_wait <= rnd[11:10];
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        mem[wr_line[13:2] + 12'(i)] <= wr_buf[i*32 +: 32];
                    end
                end else begin
                    done_wait <= done_wait - 1'b1;
                end
            end
        end
    end

endmodule

//--- tb/dcache_tb.sv
module dcache_tb import dcache_pkg::*;;
    localparam int LINE_WORDS   = line_words_default;
    localparam int SET_NUM      = set_num_default;
    localparam int NUM_RANDOM   = 200;
    localparam int WORST_CYCLES = 24;  // writeback plus refill at max delays
    localparam int LIMIT        = (NUM_RANDOM + 32) * WORST_CYCLES;

    logic                     clk = 1'b0;
    logic                     reset = 1'b1;
    cpu_req_t                 req = '0;
    logic                     busy;
    cpu_resp_t                resp;
    logic                     rd_req, rd_rdy, ret_valid;
    logic [31:0]              rd_addr, wr_addr;
    logic [LINE_WORDS*32-1:0] ret_data, wr_data;
    logic                     wr_req, wr_rdy, wr_done;

    integer      seed = 32'h2260;
    integer      rnd;
    int          err_count = 0;
    int          check_count = 0;
    int          rd_count = 0;
    int          cycles = 0;
    int          rd_before;
    logic [31:0] ref_mem [4096];
    cpu_req_t    ops [$];
    cpu_resp_t   exp_q [$];
    logic        is_load_q [$];
    logic [31:0] addr_q [$];

    dcache_top #(.LINE_WORDS(LINE_WORDS), .SET_NUM(SET_NUM)) dut_i (
        .clk(clk), .reset(reset), .req(req), .busy(busy), .resp(resp),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
        .ret_data(ret_data), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_rdy(wr_rdy), .wr_done(wr_done)
    );

    mem_model #(.LINE_WORDS(LINE_WORDS), .SEED(32'h2260)) mem_i (
        .clk(clk), .reset(reset), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_data(ret_data), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_rdy(wr_rdy), .wr_done(wr_done)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] word_pattern(logic [31:0] addr);
        return {addr[15:0] ^ addr[31:16], ~addr[15:0]} ^ 32'h3c96_a5f0;
    endfunction

    // flat memory view, updated in request order
    function automatic cpu_resp_t ref_access(cpu_req_t r);
        cpu_resp_t   e;
        logic [31:0] w;
        w = ref_mem[r.addr[13:2]];
        e.valid = 1'b1;
        e.rdata = w;
        if (r.op == OP_STORE) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (r.wstrb[b]) w[b*8 +: 8] = r.wdata[b*8 +: 8];
            end
            ref_mem[r.addr[13:2]] = w;
        end
        return e;
    endfunction

    task automatic check_resp(cpu_resp_t got, cpu_resp_t exp, logic [31:0] addr);
        check_count++;
        if (got.rdata !== exp.rdata) begin
            err_count++;
            $display("ERROR resp.rdata at addr %h: got %h expected %h", addr, got.rdata,
                     exp.rdata);
        end
    endtask

    task automatic check_rd_count(int got, int exp);
        check_count++;
        if (got != exp) begin
            err_count++;
            $display("ERROR rd_req count: got %h expected %h", got, exp);
        end
    endtask

    task automatic put_op(mem_op_e op, logic [31:0] addr, logic [3:0] strb, logic [31:0] data);
        cpu_req_t r;
        r.valid = 1'b1;
        r.op    = op;
        r.addr  = addr;
        r.wstrb = strb;
        r.wdata = data;
        ops.push_back(r);
    endtask

    task automatic drain();
        do @(posedge clk); while (ops.size() != 0 || exp_q.size() != 0);
    endtask

    // next request goes out once the current one is taken
    always @(posedge clk) begin
        if (reset) begin
            req <= '0;
        end else if (!busy) begin
            if (ops.size() != 0) begin
                cpu_req_t r;
                r = ops.pop_front();
                req <= r;
                exp_q.push_back(ref_access(r));
                is_load_q.push_back(r.op == OP_LOAD);
                addr_q.push_back(r.addr);
            end else begin
                req <= '0;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && resp.valid) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("response arrived with no request outstanding");
            end else begin
                cpu_resp_t   e;
                logic [31:0] a;
                e = exp_q.pop_front();
                a = addr_q.pop_front();
                if (is_load_q.pop_front()) check_resp(resp, e, a);
            end
        end
    end

    always @(posedge clk) begin
        if (rd_req && rd_rdy) rd_count++;
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = word_pattern({18'b0, 12'(i), 2'b00});
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        put_op(OP_LOAD, 32'h040, 4'h0, 32'h0);  // cold miss, pattern word
        put_op(OP_STORE, 32'h044, 4'b0101, 32'hdead_beef);
        put_op(OP_LOAD, 32'h048, 4'h0, 32'h0);
        put_op(OP_LOAD, 32'h044, 4'h0, 32'h0);
        drain();

        put_op(OP_STORE, 32'h050, 4'b0011, 32'h1234_5678);  // store miss then forward
        put_op(OP_LOAD, 32'h050, 4'h0, 32'h0);
        put_op(OP_STORE, 32'h048, 4'b1100, 32'hcafe_f00d);  // store hit then forward
        put_op(OP_LOAD, 32'h048, 4'h0, 32'h0);
        drain();

        // three lines into set 3, dirty evictions
        for (int i = 0; i < 3; i++) begin
            put_op(OP_STORE, 32'h030 + 32'(i) * 32'h100, 4'hf, 32'h0a0b_0c00 + 32'(i));
        end
        for (int i = 0; i < 3; i++) begin
            put_op(OP_LOAD, 32'h030 + 32'(i) * 32'h100, 4'h0, 32'h0);
        end
        drain();

        // LRU in set 0: A B A C leaves A resident, B evicted
        put_op(OP_LOAD, 32'h100, 4'h0, 32'h0);
        put_op(OP_LOAD, 32'h200, 4'h0, 32'h0);
        put_op(OP_LOAD, 32'h100, 4'h0, 32'h0);
        put_op(OP_LOAD, 32'h300, 4'h0, 32'h0);
        drain();
        rd_before = rd_count;
        put_op(OP_LOAD, 32'h100, 4'h0, 32'h0);
        drain();
        check_rd_count(rd_count - rd_before, 0);
        rd_before = rd_count;
        put_op(OP_LOAD, 32'h200, 4'h0, 32'h0);
        drain();
        check_rd_count(rd_count - rd_before, 1);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            logic [31:0] a;
            logic [31:0] d;
            rnd = $random(seed);
            a = {21'b0, rnd[10:2], 2'b00};
            d = $random(seed);
            put_op(rnd[31] ? OP_STORE : OP_LOAD, a, rnd[15:12], d);
        end
        drain();

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
logic/dcache_pkg.sv
logic/tag_dirty_array.sv
logic/line_data_array.sv
logic/lru_bank.sv
logic/lookup_stage.sv
logic/miss_ctrl.sv
logic/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dcache_tb -f list.f > run.log 2>&1 &&
    ./obj_dir/Vdcache_tb >> run.log 2>&1 ||
    echo "build or simulation did not complete" >> run.log
grep -q "STATUS: FAIL" run.log && exit 1
grep -q "STATUS: PASS" run.log || exit 1
